// ==== verilog.f ====
hw/mt_pkg.sv
hw/mt_core.sv
hw/draw_arbiter.sv
hw/draw_port.sv
hw/rng_top.sv
dv/rng_props.sv
dv/tb_rng_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rng_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rng_top -f verilog.f -o sim_rng_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_rng_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== dv/tb_rng_top.sv ====
// Random number service testbench

`timescale 1ns/1ns

module tb_rng_top;

    localparam int BUSY_LIMIT = 40000;                  // Cycles allowed for one seeding
    localparam int DONE_LIMIT = 200;
    localparam int RANDOM_DRAWS = 2500;                 // Enough to wrap the table a few times
    localparam logic [31:0] LCG_MULT = 32'd1664525;
    localparam logic [31:0] LCG_INC = 32'd1013904223;

    logic             clk;
    logic             rst;
    mt_pkg::mt_word_t seed_val;
    logic             seed_start;
    logic             req_a;
    logic             req_b;
    logic             busy;
    mt_pkg::mt_word_t data_a;
    logic             done_a;
    mt_pkg::mt_word_t data_b;
    logic             done_b;

    logic [31:0]      lcg_state;
    logic [31:0]      model_mt [mt_pkg::MT_N];
    int               model_idx;

    int               cycle_no;
    int               draws;
    int               turns;                            // Grants made under contention
    logic             open_a;                           // Request issued and not yet done
    logic             open_b;
    int               req_cycle_a;
    int               req_cycle_b;
    logic             seen_a;
    logic             seen_b;
    mt_pkg::mt_word_t held_a;
    mt_pkg::mt_word_t held_b;
    logic             last_b;

    rng_top UUT (
        .clk        (clk),
        .rst        (rst),
        .seed_val   (seed_val),
        .seed_start (seed_start),
        .req_a      (req_a),
        .req_b      (req_b),
        .busy       (busy),
        .data_a     (data_a),
        .done_a     (done_a),
        .data_b     (data_b),
        .done_b     (done_b)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random numbers and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * LCG_MULT + LCG_INC;
        return lcg_state;
    endfunction

    function automatic void seed_model(input logic [31:0] new_seed);
        logic [31:0] prev;
        int          i;
        model_mt[0] = new_seed;
        for (i = 1; i < mt_pkg::MT_N; i++) begin
            prev = model_mt[i-1];
            model_mt[i] = mt_pkg::SEED_MULT * (prev ^ (prev >> 30)) + 32'(i);
        end
        model_idx = mt_pkg::MT_N;                       // Twist before the first output
    endfunction

    function automatic logic [31:0] next_model_word();
        logic [31:0] y;
        int          k;
        if (model_idx >= mt_pkg::MT_N) begin
            for (k = 0; k < mt_pkg::MT_N; k++) begin
                y = (model_mt[k] & 32'h8000_0000)
                    | (model_mt[(k + 1) % mt_pkg::MT_N] & 32'h7fff_ffff);
                model_mt[k] = model_mt[(k + mt_pkg::MT_M) % mt_pkg::MT_N] ^ (y >> 1)
                    ^ ((y & 32'h1) != 0 ? mt_pkg::MATRIX_A : 32'h0);
            end
            model_idx = 0;
        end
        y = model_mt[model_idx];
        model_idx++;
        y = y ^ (y >> 11);
        y = y ^ ((y << 7) & mt_pkg::TEMPER_B);
        y = y ^ ((y << 15) & mt_pkg::TEMPER_C);
        y = y ^ (y >> 18);
        return y;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error: time %0t ns, %s: got %h, expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic take_word(input logic port_b, input mt_pkg::mt_word_t value);
        logic  own_open;
        int    own_cycle;
        logic  other_open;
        int    other_cycle;
        string what;
        own_open = port_b ? open_b : open_a;
        own_cycle = port_b ? req_cycle_b : req_cycle_a;
        other_open = port_b ? open_a : open_b;
        other_cycle = port_b ? req_cycle_a : req_cycle_b;
        if (port_b) begin
            what = "port b word";
        end else begin
            what = "port a word";
        end
        if (!own_open || cycle_no - own_cycle < 2) begin
            $display("A done pulse at %0t ns came without a matching request", $time);
            end_with_failure();
        end
        // Other port pending at the grant means the turn must alternate
        if (other_open && other_cycle <= cycle_no - 2) begin
            turns++;
            check_equal(32'(last_b), 32'(!port_b), "round-robin turn");
        end
        check_equal(value, next_model_word(), what);
        last_b = port_b;
        draws++;
        if (port_b) begin
            open_b = 1'b0;
            seen_b = 1'b1;
            held_b = value;
        end else begin
            open_a = 1'b0;
            seen_a = 1'b1;
            held_a = value;
        end
    endtask

    task automatic observe_outputs();
        if (done_a && done_b) begin
            $display("Both ports signalled done in the same cycle at %0t ns", $time);
            end_with_failure();
        end
        if (done_a) begin
            take_word(1'b0, data_a);
        end else if (seen_a) begin
            check_equal(data_a, held_a, "port a data between done pulses");
        end
        if (done_b) begin
            take_word(1'b1, data_b);
        end else if (seen_b) begin
            check_equal(data_b, held_b, "port b data between done pulses");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic step_cycle();
        @(negedge clk);
        cycle_no++;
        req_a = 1'b0;                                   // Strobes last one cycle
        req_b = 1'b0;
        seed_start = 1'b0;
        observe_outputs();
    endtask

    task automatic request(input logic port_b);
        if (port_b) begin
            req_b = 1'b1;
            if (!open_b) begin
                open_b = 1'b1;
                req_cycle_b = cycle_no;
            end
        end else begin
            req_a = 1'b1;
            if (!open_a) begin
                open_a = 1'b1;
                req_cycle_a = cycle_no;
            end
        end
    endtask

    task automatic wait_seeded();
        int n;
        n = 0;
        while (busy) begin
            if (n == BUSY_LIMIT) begin
                $display("Timeout: busy stayed high for %0d cycles", BUSY_LIMIT);
                end_with_failure();
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while (open_a || open_b) begin
            if (n == limit) begin
                $display("Timeout: a request got no done pulse within %0d cycles", limit);
                end_with_failure();
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic random_draws(input int count);
        int          target;
        int          n;
        logic [31:0] r;
        target = draws + count;
        n = 0;
        while (draws < target) begin
            if (n == count * 8) begin
                $display("Timeout: only %0d of %0d random draws were served",
                         draws - target + count, count);
                end_with_failure();
            end
            step_cycle();
            n++;
            r = lcg_next();
            if (r[31:30] != 2'b00) begin
                request(1'b0);
            end
            if (r[29:28] != 2'b00) begin
                request(1'b1);
            end
        end
        wait_drained(DONE_LIMIT);
    endtask

    task automatic idle_then_draw();
        int          gap;
        logic [31:0] r;
        r = lcg_next();
        gap = 16 + int'(r[31:26]);
        repeat (gap) begin
            step_cycle();                               // Nothing may be served here
        end
        step_cycle();
        request(r[25]);
        if (r[24]) begin
            request(!r[25]);
        end
        wait_drained(DONE_LIMIT);
    endtask

    task automatic reseed_with_draws();
        mt_pkg::mt_word_t new_seed;
        logic [31:0]      r;
        int               n;
        new_seed = lcg_next();
        step_cycle();
        seed_val = new_seed;
        seed_start = 1'b1;
        seed_model(new_seed);
        step_cycle();
        check_equal(32'(busy), 32'd1, "busy after seed_start");
        for (n = 0; n < 40; n++) begin
            step_cycle();
            r = lcg_next();
            if (r[31]) begin
                request(1'b0);
            end
            if (r[30]) begin
                request(1'b1);
            end
        end
        wait_seeded();
        random_draws(800);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        seed_val = '0;
        seed_start = 1'b0;
        req_a = 1'b0;
        req_b = 1'b0;
        lcg_state = 32'h95b3_df56;
        cycle_no = 0;
        draws = 0;
        turns = 0;
        open_a = 1'b0;
        open_b = 1'b0;
        req_cycle_a = 0;
        req_cycle_b = 0;
        seen_a = 1'b0;
        seen_b = 1'b0;
        held_a = '0;
        held_b = '0;
        last_b = 1'b1;                                  // Port a goes first after reset
        seed_model(mt_pkg::DEFAULT_SEED);

        repeat (8) @(negedge clk);
        rst = 1'b0;
        step_cycle();
        check_equal(32'(busy), 32'd1, "busy after reset");
        wait_seeded();

        request(1'b0);
        wait_drained(DONE_LIMIT);
        check_equal(data_a, 32'd3499211612, "first word for the default seed");

        random_draws(RANDOM_DRAWS);
        repeat (6) begin
            idle_then_draw();
        end
        reseed_with_draws();
        repeat (3) begin
            idle_then_draw();
        end

        if (turns == 0) begin
            $display("No grant under contention was seen during the run");
            end_with_failure();
        end else begin
            $display("Draws checked: %0d, contended grants: %0d", draws, turns);
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// ==== dv/rng_props.sv ====
// Stream and done assertions

`timescale 1ns/1ns

module rng_props (
    input logic             clk,
    input logic             rst,
    input logic             busy,
    input logic             done_a,
    input logic             done_b,
    input mt_pkg::mt_word_t word,
    input logic             valid,
    input logic             ready
);

    done_one_hot: assert property (@(posedge clk) disable iff (rst) !(done_a && done_b))
        else $error("done_a and done_b were high together");

    // A stalled core word must not move
    word_held: assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> $stable(word))
        else $error("core word changed while valid and not ready");

    // No word is offered while seeding, so no grant and no done can follow
    no_done_when_busy: assert property (@(posedge clk) disable iff (rst)
        busy |=> !(done_a || done_b))
        else $error("done pulse right after a seeding cycle");

endmodule

bind rng_top rng_props props (
    .clk     (clk),
    .rst     (rst),
    .busy    (busy),
    .done_a  (done_a),
    .done_b  (done_b),
    .word    (mt_word),
    .valid   (mt_valid),
    .ready   (mt_ready)
);

// ==== hw/rng_top.sv ====
// Shared random number service

`timescale 1ns/1ns

module rng_top #(
    parameter mt_pkg::mt_word_t INIT_SEED = mt_pkg::DEFAULT_SEED
) (
    input  logic             clk,
    input  logic             rst,
    input  mt_pkg::mt_word_t seed_val,
    input  logic             seed_start,
    input  logic             req_a,
    input  logic             req_b,
    output logic             busy,
    output mt_pkg::mt_word_t data_a,
    output logic             done_a,
    output mt_pkg::mt_word_t data_b,
    output logic             done_b
);

    mt_pkg::mt_word_t mt_word;
    logic             mt_valid;
    logic             mt_ready;
    logic             pending_a;
    logic             pending_b;
    logic             grant_a;
    logic             grant_b;

    mt_core #(
        .INIT_SEED (INIT_SEED)
    ) core (
        .clk        (clk),
        .rst        (rst),
        .seed_val   (seed_val),
        .seed_start (seed_start),
        .busy       (busy),
        .word       (mt_word),
        .valid      (mt_valid),
        .ready      (mt_ready)
    );

    draw_arbiter arbiter (
        .clk       (clk),
        .rst       (rst),
        .valid     (mt_valid),
        .ready     (mt_ready),
        .pending_a (pending_a),
        .pending_b (pending_b),
        .grant_a   (grant_a),
        .grant_b   (grant_b)
    );

    draw_port port_a (
        .clk     (clk),
        .rst     (rst),
        .req     (req_a),
        .grant   (grant_a),
        .word    (mt_word),
        .pending (pending_a),
        .data    (data_a),
        .done    (done_a)
    );

    draw_port port_b (
        .clk     (clk),
        .rst     (rst),
        .req     (req_b),
        .grant   (grant_b),
        .word    (mt_word),
        .pending (pending_b),
        .data    (data_b),
        .done    (done_b)
    );

endmodule

// ==== hw/draw_port.sv ====
// Client draw port

`timescale 1ns/1ns

module draw_port (
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  logic             grant,
    input  mt_pkg::mt_word_t word,
    output logic             pending,
    output mt_pkg::mt_word_t data,
    output logic             done
);

    logic             pending_reg;
    logic             done_reg;
    mt_pkg::mt_word_t data_reg;

    assign pending = pending_reg;
    assign done = done_reg;
    assign data = data_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_reg <= 1'b0;
            done_reg <= 1'b0;
        end else begin
            done_reg <= grant;                          // Result is visible the cycle after grant
            if (grant) begin
                pending_reg <= 1'b0;
            end else if (req) begin
                pending_reg <= 1'b1;                    // A repeat while pending changes nothing
            end
        end
    end

    // Held result

    always_ff @(posedge clk) begin
        if (grant) begin
            data_reg <= word;                           // Kept until the next grant
        end
    end

endmodule

// ==== hw/draw_arbiter.sv ====
// Round-robin draw arbiter

`timescale 1ns/1ns

module draw_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic valid,
    output logic ready,
    input  logic pending_a,
    input  logic pending_b,
    output logic grant_a,
    output logic grant_b
);

    logic last_b;                                       // Port b won the last grant
    logic contend;

    assign contend = pending_a && pending_b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        grant_a = 1'b0;
        grant_b = 1'b0;
        if (valid) begin
            if (contend) begin
                grant_a = last_b;                       // Alternate on contention
                grant_b = !last_b;
            end else begin
                grant_a = pending_a;
                grant_b = pending_b;
            end
        end
    end

    assign ready = grant_a || grant_b;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Last winner
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            last_b <= 1'b1;                             // Gives port a the first turn
        end else if (grant_a) begin
            last_b <= 1'b0;
        end else if (grant_b) begin
            last_b <= 1'b1;
        end
    end

endmodule

// ==== hw/mt_core.sv ====
// MT19937 generator core

`timescale 1ns/1ns

module mt_core #(
    parameter mt_pkg::mt_word_t INIT_SEED = mt_pkg::DEFAULT_SEED
) (
    input  logic             clk,
    input  logic             rst,
    input  mt_pkg::mt_word_t seed_val,
    input  logic             seed_start,
    output logic             busy,
    output mt_pkg::mt_word_t word,
    output logic             valid,
    input  logic             ready
);

    localparam int AW = $clog2(mt_pkg::MT_N);
    localparam logic [AW-1:0] LAST_IDX = AW'(mt_pkg::MT_N - 1);
    localparam logic [AW-1:0] TAB_END = AW'(mt_pkg::MT_N);
    localparam logic [AW-1:0] MID_IDX = AW'(mt_pkg::MT_M);

    localparam logic ST_SEED = 1'b0;
    localparam logic ST_RUN = 1'b1;

    logic state_reg;
    logic state_next;

    mt_pkg::mt_word_t mt_ram [mt_pkg::MT_N];

    logic [AW-1:0]    mti_reg;
    logic [AW-1:0]    mti_next;
    logic [AW-1:0]    rd_a_ptr_reg;
    logic [AW-1:0]    rd_a_ptr_next;
    logic [AW-1:0]    rd_b_ptr_reg;
    logic [AW-1:0]    rd_b_ptr_next;
    mt_pkg::mt_word_t rd_a_data;
    mt_pkg::mt_word_t rd_b_data;

    logic             wr_en;
    logic [AW-1:0]    wr_ptr;
    mt_pkg::mt_word_t wr_data;

    mt_pkg::mt_word_t save_reg;
    mt_pkg::mt_word_t save_next;

    mt_pkg::mt_word_t product_reg;
    mt_pkg::mt_word_t product_next;
    mt_pkg::mt_word_t factor1_reg;
    mt_pkg::mt_word_t factor1_next;
    mt_pkg::mt_word_t factor2_reg;
    mt_pkg::mt_word_t factor2_next;
    logic             mul_done_reg;
    logic             mul_done_next;
    mt_pkg::mt_word_t seed_sum;

    mt_pkg::mt_word_t word_reg;
    mt_pkg::mt_word_t word_next;
    logic             valid_reg;
    logic             valid_next;
    logic             load;

    mt_pkg::mt_word_t y1;
    mt_pkg::mt_word_t y2;
    mt_pkg::mt_word_t y3;
    mt_pkg::mt_word_t y4;
    mt_pkg::mt_word_t y5;

    function automatic logic [AW-1:0] next_idx(input logic [AW-1:0] idx);
        return (idx == LAST_IDX) ? '0 : idx + 1'b1;
    endfunction

    assign busy = (state_reg == ST_SEED);
    assign word = word_reg;
    assign valid = valid_reg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Twist and tempering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign y1 = {save_reg[31], rd_a_data[30:0]};        // Upper bit of mt[i], lower of mt[i+1]
    assign y2 = rd_b_data ^ (y1 >> 1) ^ (y1[0] ? mt_pkg::MATRIX_A : '0);
    assign y3 = y2 ^ (y2 >> mt_pkg::TEMPER_U);
    assign y4 = y3 ^ ((y3 << mt_pkg::TEMPER_S) & mt_pkg::TEMPER_B);
    assign y5 = y4 ^ ((y4 << mt_pkg::TEMPER_T) & mt_pkg::TEMPER_C);

    assign seed_sum = product_reg + mt_pkg::mt_word_t'(mti_reg);

    // Output register is refilled when empty or when its word is taken
    assign load = !valid_reg || ready;

    always_comb begin
        state_next = state_reg;
        mti_next = mti_reg;
        rd_a_ptr_next = rd_a_ptr_reg;
        rd_b_ptr_next = rd_b_ptr_reg;
        save_next = save_reg;
        product_next = product_reg;
        factor1_next = factor1_reg;
        factor2_next = factor2_reg;
        mul_done_next = mul_done_reg;
        word_next = word_reg;
        valid_next = valid_reg;
        wr_en = 1'b0;
        wr_ptr = mti_reg;
        wr_data = y2;

        if (state_reg == ST_SEED) begin
            rd_a_ptr_next = '0;
            rd_b_ptr_next = MID_IDX;
            if (!mul_done_reg) begin
                // One multiplier bit per cycle
                factor1_next = factor1_reg << 1;
                factor2_next = factor2_reg >> 1;
                mul_done_next = (factor2_reg >> 1) == '0;
                if (factor2_reg[0]) begin
                    product_next = product_reg + factor1_reg;
                end
            end else if (mti_reg != TAB_END) begin
                wr_en = 1'b1;
                wr_data = seed_sum;
                mti_next = mti_reg + 1'b1;
                product_next = '0;
                factor1_next = mt_pkg::SEED_MULT;
                factor2_next = seed_sum ^ (seed_sum >> mt_pkg::SEED_SHIFT);
                mul_done_next = 1'b0;
            end else begin
                mti_next = '0;
                rd_a_ptr_next = AW'(1);
                save_next = rd_a_data;                  // mt[0] is read back here
                state_next = ST_RUN;
            end
        end else if (load) begin
            wr_en = 1'b1;
            mti_next = next_idx(mti_reg);
            rd_a_ptr_next = next_idx(rd_a_ptr_reg);
            rd_b_ptr_next = next_idx(rd_b_ptr_reg);
            save_next = rd_a_data;
            word_next = y5 ^ (y5 >> mt_pkg::TEMPER_L);
            valid_next = 1'b1;
        end

        if (seed_start) begin
            state_next = ST_SEED;
            mti_next = '0;
            product_next = seed_val;
            mul_done_next = 1'b1;
            valid_next = 1'b0;                          // Old word is dropped
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mt_ram[wr_ptr] <= wr_data;
        end
        rd_a_data <= mt_ram[rd_a_ptr_next];
        rd_b_data <= mt_ram[rd_b_ptr_next];
    end

    always_ff @(posedge clk) begin
        save_reg <= save_next;
        factor1_reg <= factor1_next;
        factor2_reg <= factor2_next;
        word_reg <= word_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_SEED;
            mti_reg <= '0;
            rd_a_ptr_reg <= '0;
            rd_b_ptr_reg <= '0;
            product_reg <= INIT_SEED;
            mul_done_reg <= 1'b1;
            valid_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            mti_reg <= mti_next;
            rd_a_ptr_reg <= rd_a_ptr_next;
            rd_b_ptr_reg <= rd_b_ptr_next;
            product_reg <= product_next;
            mul_done_reg <= mul_done_next;
            valid_reg <= valid_next;
        end
    end

endmodule

// ==== hw/mt_pkg.sv ====
// Mersenne Twister constants

package mt_pkg;

    localparam int MT_W = 32;

    typedef logic [MT_W-1:0] mt_word_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MT_N = 624;                          // Words in the state table
    localparam int MT_M = 397;                          // Distance to the middle word

    localparam mt_word_t MATRIX_A = 32'h9908_b0df;      // Twist matrix row

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tempering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam mt_word_t TEMPER_B = 32'h9d2c_5680;
    localparam mt_word_t TEMPER_C = 32'hefc6_0000;

    localparam int TEMPER_U = 11;
    localparam int TEMPER_S = 7;
    localparam int TEMPER_T = 15;
    localparam int TEMPER_L = 18;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Seeding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam mt_word_t SEED_MULT = 32'd1812433253;    // Knuth multiplier for the fill
    localparam int SEED_SHIFT = 30;

    // Seed used after reset
    localparam mt_word_t DEFAULT_SEED = 32'd5489;

endpackage
